/* hw/rv_core_params.svh */
/* RV32I core parameters
   widths, register count and reset vector */

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// architectural registers, x0 included
`define RV_NUM_REGS 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// one strobe bit per byte lane
`define RV_STRB_W 4

`endif

/* hw/rv_core_pkg.sv */
/* RV32I core types
   instruction formats, opcodes, ALU ops and request structs */

`default_nettype none

`include "rv_core_params.svh"

package rv_core_pkg;

    // instruction word, one view per format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_u;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_REG,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_e;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [2:0]            funct3;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_e               alu_op;
        op_a_sel_e             op_a_sel;
        logic                  use_imm;    // operand b from imm
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  is_load;
        logic                  is_store;
        logic                  reg_write;
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   addr;
        logic                  we;
        logic [`RV_STRB_W-1:0] wstrb;
        logic [`RV_XLEN-1:0]   wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* hw/rv_core_regfile.sv */
/* integer register file
   two combinational reads, one write port, x0 reads zero */

`default_nettype none

`include "rv_core_params.svh"

module rv_core_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hw/rv_core_ctrl.sv */
/* core control FSM
   sequences fetch, execute, data access and writeback */

`default_nettype none

module rv_core_ctrl
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  decoded_t dec,
    input  logic     mem_ack,
    output logic     mem_req,
    output logic     data_phase,
    output logic     ir_load,
    output logic     pc_load,
    output logic     reg_we
);

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        DATA,
        DATA_WAIT,
        WRITEBACK
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH:      state_nxt = FETCH_WAIT;
            FETCH_WAIT: if (mem_ack) state_nxt = EXECUTE;
            EXECUTE: begin
                // only loads and stores touch memory again
                if (dec.is_load || dec.is_store) begin
                    state_nxt = DATA;
                end else begin
                    state_nxt = WRITEBACK;
                end
            end
            DATA:       state_nxt = DATA_WAIT;
            DATA_WAIT:  if (mem_ack) state_nxt = WRITEBACK;
            WRITEBACK:  state_nxt = FETCH;
            default:    state_nxt = FETCH;
        endcase
    end

    assign mem_req    = (state == FETCH) || (state == DATA);       // one-cycle strobe
    assign data_phase = (state == DATA) || (state == DATA_WAIT);   // held until ack
    assign ir_load    = (state == FETCH_WAIT) && mem_ack;
    assign pc_load    = (state == WRITEBACK);

    // x0 never written
    assign reg_we = (state == WRITEBACK) && dec.reg_write && (dec.rd != '0);

endmodule

`default_nettype wire

/* hw/rv_core_decode.sv */
/* instruction decoder
   opcode to format, immediate generation and ALU op select */

`default_nettype none

module rv_core_decode
    import rv_core_pkg::*;
(
    input  inst_u    inst,
    output decoded_t dec
);

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic reg_form);
        alu_op_e op;
        case (f3)
            3'b000:  op = (reg_form && f7[5]) ? ALU_SUB : ALU_ADD;  // no SUBI
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = f7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // sign-extended immediates, one per format
    assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm_b = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                    inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                    inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        dec          = '0;
        dec.rs1      = inst.r_fmt.rs1;
        dec.rs2      = inst.r_fmt.rs2;
        dec.rd       = inst.r_fmt.rd;
        dec.funct3   = inst.r_fmt.funct3;
        dec.alu_op   = ALU_ADD;
        dec.op_a_sel = OPA_REG;
        case (opcode_e'(inst.r_fmt.opcode))
            OP_LUI: begin
                dec.imm       = imm_u;
                dec.op_a_sel  = OPA_ZERO;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.op_a_sel  = OPA_PC;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_JAL: begin
                dec.imm       = imm_j;
                dec.op_a_sel  = OPA_PC;
                dec.use_imm   = 1'b1;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_JALR: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            OP_LOAD: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_STORE: begin
                dec.imm      = imm_s;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            OP_IMM: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.alu_op    = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7, 1'b0);
                dec.reg_write = 1'b1;
            end
            OP_REG: begin
                dec.alu_op    = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7, 1'b1);
                dec.reg_write = 1'b1;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_core_exec.sv */
/* execute stage
   ALU, branch compare, next PC and writeback select */

`default_nettype none

`include "rv_core_params.svh"

module rv_core_exec
    import rv_core_pkg::*;
(
    input  decoded_t            dec,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] load_data,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] next_pc,
    output logic [`RV_XLEN-1:0] wb_data
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] br_target;
    logic                taken;

    always_comb begin
        case (dec.op_a_sel)
            OPA_PC:   op_a = pc;
            OPA_ZERO: op_a = '0;     // LUI
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch compare on raw register values
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + dec.imm;

    always_comb begin
        if (dec.is_jalr) begin
            next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};  // bit 0 cleared
        end else if (dec.is_jal || (dec.is_branch && taken)) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (dec.is_load) begin
            wb_data = load_data;
        end else if (dec.is_jal || dec.is_jalr) begin
            wb_data = pc_plus4;  // link
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_core_lsu.sv */
/* load/store unit
   store lane placement with strobes, load extract and extend */

`default_nettype none

`include "rv_core_params.svh"

module rv_core_lsu
    import rv_core_pkg::*;
(
    input  decoded_t            dec,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] store_data,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output mem_req_t            data_req,
    output logic [`RV_XLEN-1:0] load_data
);

    logic [1:0]          byte_off;
    logic [`RV_XLEN-1:0] rd_shift;

    assign byte_off = addr[1:0];

    always_comb begin
        data_req.addr  = {addr[`RV_XLEN-1:2], 2'b00};    // word aligned
        data_req.we    = dec.is_store;
        data_req.wdata = store_data << {byte_off, 3'b000};
        case (dec.funct3)
            3'b000:  data_req.wstrb = 4'b0001 << byte_off;  // SB
            3'b001:  data_req.wstrb = 4'b0011 << byte_off;  // SH
            3'b010:  data_req.wstrb = 4'b1111;
            default: data_req.wstrb = 4'b0000;
        endcase
    end

    // addressed lane moved down to bit 0
    assign rd_shift = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};    // LB
            3'b001:  load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};  // LH
            3'b100:  load_data = {24'b0, rd_shift[7:0]};
            3'b101:  load_data = {16'b0, rd_shift[15:0]};
            default: load_data = mem_rdata;                            // LW
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
/* RV32I multi-cycle core top
   PC and instruction registers, single shared memory port */

`default_nettype none

`include "rv_core_params.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    output logic                mem_req,
    output mem_req_t            mem_out,
    input  logic                mem_ack,
    input  logic [`RV_XLEN-1:0] mem_rdata
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    inst_u               inst_q;
    logic [`RV_XLEN-1:0] rdata_q;      // last memory read
    decoded_t            dec;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] load_data;
    mem_req_t            data_req;
    mem_req_t            fetch_req;
    logic                data_phase;
    logic                ir_load;
    logic                pc_load;
    logic                reg_we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) inst_q <= inst_u'(mem_rdata);
        if (mem_ack) rdata_q <= mem_rdata;   // load data kept for writeback
    end

    assign fetch_req = '{addr: pc, we: 1'b0, wstrb: '0, wdata: '0};
    assign mem_out   = data_phase ? data_req : fetch_req;

    rv_core_ctrl i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .mem_ack    (mem_ack),
        .mem_req    (mem_req),
        .data_phase (data_phase),
        .ir_load    (ir_load),
        .pc_load    (pc_load),
        .reg_we     (reg_we)
    );

    rv_core_decode i_decode (
        .inst (inst_q),
        .dec  (dec)
    );

    rv_core_exec i_exec (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .load_data  (load_data),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .wb_data    (wb_data)
    );

    rv_core_lsu i_lsu (
        .dec        (dec),
        .addr       (alu_result),
        .store_data (rs2_data),
        .mem_rdata  (rdata_q),
        .data_req   (data_req),
        .load_data  (load_data)
    );

    rv_core_regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (reg_we),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

endmodule

`default_nettype wire

/* sim/rv_core_tests.svh */
/* directed tests for the RV32I core
   instruction encoders, program helpers and one task per feature */

`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs1, input int rs2,
                                           input int f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] op);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic int here();
        return prog.size() * 4;     // byte address of the next instruction
    endfunction

    // lui + addi, upper part rounded for the signed low part
    task automatic load_const(input int rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        prog.push_back(u_type(int'(hi), rd, OP_LUI));
        prog.push_back(i_type(int'($signed(value[11:0])), rd, 0, rd, OP_IMM));
    endtask

    task automatic finish_program();
        prog.push_back(i_type(1, 0, 0, 31, OP_IMM));
        prog.push_back(s_type('h3FC, 31, 0, 2));    // done word
        prog.push_back(j_type(0, 0));               // spin here
    endtask

    // RV32I ALU rules, index in ADD SUB SLL SLT SLTU XOR SRL SRA OR AND order
    function automatic logic [31:0] alu_expect(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << sh;
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> sh;
            7:       return $unsigned($signed(a) >>> sh);
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_rule(input int f3, input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            7:       return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] word, input logic [31:0] data,
                                               input int off, input int nbytes);
        logic [31:0] res;
        res = word;
        for (int i = 0; i < nbytes; i++) begin
            res[8*(off+i) +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] load_extract(input logic [31:0] word, input int off,
                                                 input int f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = (off >= 2) ? word[31:16] : word[15:0];
        case (f3)
            0:       return {{24{b[7]}}, b};
            4:       return {24'b0, b};
            1:       return {{16{h[15]}}, h};
            default: return {16'b0, h};
        endcase
    endfunction

    task automatic first_fetch_test();
        int cycles;
        prog.delete();
        prog.push_back(j_type(0, 0));
        apply_reset();
        cycles = 0;
        @(negedge clk);
        while (!mem_req && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_req) begin
            $display("first fetch: no memory request within 10 cycles of reset release");
            errors++;
        end else begin
            if (cycles != 0) begin
                $display("FAILED first fetch: request cycle expected 0 actual %0d", cycles);
                errors++;
            end
            if (mem_out.addr !== `RV_RESET_PC) begin
                $display("FAILED first fetch: address expected 0x%h actual 0x%h",
                         `RV_RESET_PC, mem_out.addr);
                errors++;
            end
            if (mem_out.we !== 1'b0) begin
                $display("FAILED first fetch: we expected 0 actual %b", mem_out.we);
                errors++;
            end
        end
        report_test("first fetch");
    endtask

    task automatic alu_test();
        int          r_f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        int          r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        int          i_f3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        int          i_imm [9] = '{-200, 5, 5, 'h5A5, 'h0F0, 'h7F0, 3, 7, 'h407};
        int          i_op [9] = '{0, 3, 4, 5, 8, 9, 2, 6, 7};
        logic [31:0] a;
        logic [31:0] b;
        a = 32'hFFFF_FF85;   // -123
        b = 32'h0000_0025;   // shift amount 5 from the low bits
        prog.delete();
        load_const(1, a);
        load_const(2, b);
        for (int k = 0; k < 10; k++) begin
            prog.push_back(r_type(r_alt[k] * 32, 2, 1, r_f3[k], 3));
            prog.push_back(s_type('h200 + 4 * k, 3, 0, 2));
        end
        for (int k = 0; k < 9; k++) begin
            prog.push_back(i_type(i_imm[k], 1, i_f3[k], 4, OP_IMM));
            prog.push_back(s_type('h240 + 4 * k, 4, 0, 2));
        end
        finish_program();
        run_program("alu");
        for (int k = 0; k < 10; k++) begin
            check_word("alu", 'h200 + 4 * k, alu_expect(k, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            check_word("alu", 'h240 + 4 * k, alu_expect(i_op[k], a, 32'(i_imm[k])));
        end
        report_test("alu");
    endtask

    task automatic branch_test();
        int          f3 [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int          ra [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
        int          rb [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
        logic [31:0] val [4];
        val[0] = '0;
        val[1] = 32'hFFFF_FFFB;
        val[2] = 32'd3;
        val[3] = 32'd3;
        prog.delete();
        for (int r = 1; r < 4; r++) begin
            load_const(r, val[r]);
        end
        load_const(11, 32'hA1);    // not taken marker
        load_const(12, 32'hB2);    // taken marker
        for (int k = 0; k < 12; k++) begin
            prog.push_back(b_type(12, ra[k], rb[k], f3[k]));
            prog.push_back(s_type('h200 + 4 * k, 11, 0, 2));
            prog.push_back(j_type(8, 0));
            prog.push_back(s_type('h200 + 4 * k, 12, 0, 2));
        end
        finish_program();
        run_program("branch");
        for (int k = 0; k < 12; k++) begin
            check_word("branch", 'h200 + 4 * k,
                       branch_rule(f3[k], val[ra[k]], val[rb[k]]) ? 32'hB2 : 32'hA1);
        end
        report_test("branch");
    endtask

    task automatic jump_test();
        int jal_at;
        int auipc_at;
        prog.delete();
        jal_at = here();
        prog.push_back(j_type(8, 5));
        prog.push_back(i_type(99, 0, 0, 20, OP_IMM));     // skipped
        prog.push_back(s_type('h200, 5, 0, 2));
        auipc_at = here();
        prog.push_back(u_type(0, 6, OP_AUIPC));
        prog.push_back(i_type(17, 6, 0, 6, OP_IMM));      // odd target
        prog.push_back(i_type(0, 6, 0, 7, OP_JALR));
        prog.push_back(i_type(99, 0, 0, 20, OP_IMM));     // skipped
        prog.push_back(u_type(0, 8, OP_AUIPC));           // landing pc
        prog.push_back(s_type('h204, 7, 0, 2));
        prog.push_back(s_type('h208, 8, 0, 2));
        prog.push_back(s_type('h20C, 20, 0, 2));
        finish_program();
        run_program("jump");
        check_word("jump", 'h200, jal_at + 4);
        check_word("jump", 'h204, auipc_at + 12);
        check_word("jump", 'h208, (auipc_at + 17) & ~1);
        check_word("jump", 'h20C, 32'h0);
        report_test("jump");
    endtask

    task automatic load_store_test();
        int          st_f3 [6] = '{0, 0, 0, 0, 1, 1};
        int          st_off [6] = '{0, 1, 2, 3, 0, 2};
        int          ld_f3 [12] = '{0, 0, 0, 0, 4, 4, 4, 4, 1, 1, 5, 5};
        int          ld_off [12] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2};
        logic [31:0] fill;
        logic [31:0] data;
        logic [31:0] src;
        fill = 32'h1122_3344;
        data = 32'h8765_43A5;
        src  = 32'h80FF_7F01;
        prog.delete();
        load_const(1, fill);
        load_const(2, data);
        load_const(3, src);
        prog.push_back(s_type('h280, 3, 0, 2));
        for (int k = 0; k < 6; k++) begin
            prog.push_back(s_type('h200 + 4 * k, 1, 0, 2));
            prog.push_back(s_type('h200 + 4 * k + st_off[k], 2, 0, st_f3[k]));
        end
        for (int k = 0; k < 12; k++) begin
            prog.push_back(i_type('h280 + ld_off[k], 0, ld_f3[k], 4, OP_LOAD));
            prog.push_back(s_type('h240 + 4 * k, 4, 0, 2));
        end
        finish_program();
        run_program("load store");
        for (int k = 0; k < 6; k++) begin
            check_word("load store", 'h200 + 4 * k,
                       lane_merge(fill, data, st_off[k], (st_f3[k] == 0) ? 1 : 2));
        end
        for (int k = 0; k < 12; k++) begin
            check_word("load store", 'h240 + 4 * k, load_extract(src, ld_off[k], ld_f3[k]));
        end
        report_test("load store");
    endtask

    task automatic upper_imm_test();
        int auipc_at;
        prog.delete();
        prog.push_back(u_type('hABCDE, 1, OP_LUI));
        auipc_at = here();
        prog.push_back(u_type('h12345, 2, OP_AUIPC));
        prog.push_back(s_type('h200, 1, 0, 2));
        prog.push_back(s_type('h204, 2, 0, 2));
        prog.push_back(i_type(123, 0, 0, 0, OP_IMM));    // writes to x0 are dropped
        prog.push_back(u_type('hFFFFF, 0, OP_LUI));
        prog.push_back(s_type('h208, 1, 0, 2));          // nonzero first
        prog.push_back(s_type('h208, 0, 0, 2));
        finish_program();
        run_program("upper imm and x0");
        check_word("upper imm and x0", 'h200, 32'hABCDE << 12);
        check_word("upper imm and x0", 'h204, auipc_at + (32'h12345 << 12));
        check_word("upper imm and x0", 'h208, 32'h0);
        report_test("upper imm and x0");
    endtask

`endif

/* sim/rv_core_tb.sv */
/* rv_core testbench
   clock, reset, memory model with random latency and test sequence */

`default_nettype none

`include "rv_core_params.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    logic                clk;
    logic                reset;
    logic                mem_req;
    mem_req_t            mem_out;
    logic                mem_ack;
    logic [`RV_XLEN-1:0] mem_rdata;

    logic [31:0] mem [1024];    // 4 KiB, word addressed
    logic [31:0] prog [$];      // program image for the next run
    bit          done_seen;
    int          errors;        // in the current test
    int          tests_run;
    int          tests_failed;

    rv_core i_rv_core (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_out   (mem_out),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one request at a time, acked 1 to 4 cycles later
    initial begin
        mem_req_t req;
        int       lat;
        int       cnt;
        void'($urandom(60));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req && !reset) begin
                req = mem_out;
                lat = $urandom_range(4, 1);
                cnt = 0;
                while (cnt < lat && !reset) begin
                    @(posedge clk);
                    cnt++;
                end
                if (!reset) begin   // a pending access is dropped by reset
                    #1;
                    mem_ack   = 1'b1;
                    mem_rdata = mem[req.addr[11:2]];
                    if (req.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (req.wstrb[b]) begin
                                mem[req.addr[11:2]][8*b +: 8] = req.wdata[8*b +: 8];
                            end
                        end
                        if (req.addr[11:0] == 12'h3FC) done_seen = 1'b1;
                    end
                    @(posedge clk);
                    #1;
                    mem_ack = 1'b0;
                end
            end
        end
    end

    // reset held 8 cycles, program loaded meanwhile
    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        for (int i = 0; i < 1024; i++) begin
            mem[i] = '0;
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
        done_seen = 1'b0;
        #1;
        reset = 1'b0;
    endtask

    task automatic run_program(input string name);
        int cycles;
        apply_reset();
        cycles = 0;
        while (!done_seen && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            $display("%s: program did not write the done word within %0d cycles", name, cycles);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input int addr, input logic [31:0] expected);
        logic [31:0] actual;
        actual = mem[addr >> 2];
        if (actual !== expected) begin
            $display("FAILED %s: word 0x%h expected 0x%h actual 0x%h",
                     name, addr, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    `include "rv_core_tests.svh"

    initial begin
        reset        = 1'b1;
        done_seen    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        first_fetch_test();
        alu_test();
        branch_test();
        jump_test();
        load_store_test();
        upper_imm_test();
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+hw
+incdir+sim
hw/rv_core_pkg.sv
hw/rv_core_regfile.sv
hw/rv_core_ctrl.sv
hw/rv_core_decode.sv
hw/rv_core_exec.sv
hw/rv_core_lsu.sv
hw/rv_core.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
